// ==== int_alu.f ====
+incdir+verilog
verilog/int_alu_pkg.sv
verilog/alu_adder.sv
verilog/alu_shifter.sv
verilog/alu_compare.sv
verilog/polar_simd.sv
verilog/alu_result_stage.sv
verilog/int_alu.sv
test/int_alu_chk.sv
test/int_alu_tb.sv

// ==== Bender.yml ====
package:
  name: int_alu

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/int_alu_pkg.sv
      - verilog/alu_adder.sv
      - verilog/alu_shifter.sv
      - verilog/alu_compare.sv
      - verilog/polar_simd.sv
      - verilog/alu_result_stage.sv
      - verilog/int_alu.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/int_alu_chk.sv
      - test/int_alu_tb.sv

// ==== test/int_alu_tb.sv ====
`timescale 1ns/1ps
`include "int_alu_config.svh"

module int_alu_tb;

    localparam int reset_cycles   = 5;
    localparam int num_rows       = 37;
    localparam int num_random     = 40;
    localparam int timeout_cycles = reset_cycles + num_rows + num_random + 20;

    logic                     clk_i;
    logic                     arst_n_i;
    int_alu_pkg::alu_op_e     op_i;
    logic [`INT_ALU_XLEN-1:0] operand_a_i;
    logic [`INT_ALU_XLEN-1:0] operand_b_i;
    logic [`INT_ALU_XLEN-1:0] result_o;
    logic                     branch_o;

    // Stimulus table
    int_alu_pkg::alu_op_e     tbl_op  [num_rows];
    logic [`INT_ALU_XLEN-1:0] tbl_a   [num_rows];
    logic [`INT_ALU_XLEN-1:0] tbl_b   [num_rows];
    logic [`INT_ALU_XLEN-1:0] tbl_res [num_rows];
    logic                     tbl_br  [num_rows];
    int                       row_count;

    // Operation in flight awaiting its check
    logic                     pend_valid;
    int_alu_pkg::alu_op_e     pend_op;
    logic [`INT_ALU_XLEN-1:0] pend_res;
    logic                     pend_br;

    int                       errors;
    int                       checks;
    int                       cycle_count;
    integer                   seed;
    int_alu_pkg::alu_op_e     rand_op;
    int_alu_pkg::operand_u    rand_a;
    int_alu_pkg::operand_u    rand_b;
    logic [`INT_ALU_XLEN-1:0] rand_exp;

    int_alu dut (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .result_o    (result_o),
        .branch_o    (branch_o)
    );

    bind int_alu int_alu_chk chk (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .op_i     (op_i),
        .result_o (result_o),
        .branch_o (branch_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic check_value(input logic [`INT_ALU_XLEN-1:0] actual,
                               input logic [`INT_ALU_XLEN-1:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic add_row(input int_alu_pkg::alu_op_e op, input logic [63:0] a,
                           input logic [63:0] b, input logic [63:0] res, input logic br);
        tbl_op[row_count]  = op;
        tbl_a[row_count]   = a;
        tbl_b[row_count]   = b;
        tbl_res[row_count] = res;
        tbl_br[row_count]  = br;
        row_count++;
    endtask

    // Expected lane value straight from the polar rules
    function automatic logic [`INT_ALU_LANE_W-1:0] polar_lane(
        input int_alu_pkg::alu_op_e              op,
        input logic signed [`INT_ALU_LANE_W-1:0] a,
        input logic signed [`INT_ALU_LANE_W-1:0] b
    );
        int va;
        int vb;
        int mag;
        int res;
        va  = a;
        vb  = b;
        mag = (va < 0) ? -va : va;
        if (((vb < 0) ? -vb : vb) < mag) begin
            mag = (vb < 0) ? -vb : vb;
        end
        case (op)
            int_alu_pkg::op_pl_r:      res = (vb != 1 && va < 0) ? 1 : 0;
            int_alu_pkg::op_pl_f:      res = ((va < 0) != (vb < 0)) ? -mag : mag;
            int_alu_pkg::op_pl_addsat: res = va + vb;
            default:                   res = va - vb;
        endcase
        if (op inside {int_alu_pkg::op_pl_addsat, int_alu_pkg::op_pl_subsat}) begin
            if (res > `INT_ALU_SAT_MAX) res = `INT_ALU_SAT_MAX;
            if (res < `INT_ALU_SAT_MIN) res = `INT_ALU_SAT_MIN;
        end
        return res[`INT_ALU_LANE_W-1:0];
    endfunction

    task automatic check_pending();
        if (pend_valid) begin
            check_value(result_o, pend_res, {pend_op.name(), " result"});
            check_value(64'(branch_o), 64'(pend_br), {pend_op.name(), " branch"});
        end
    endtask

    // One operation per cycle while the previous one is checked
    task automatic issue_op(input int_alu_pkg::alu_op_e op, input logic [63:0] a,
                            input logic [63:0] b, input logic [63:0] res, input logic br);
        @(posedge clk_i);
        op_i        <= op;
        operand_a_i <= a;
        operand_b_i <= b;
        @(negedge clk_i);
        check_pending();
        pend_valid = 1'b1;
        pend_op    = op;
        pend_res   = res;
        pend_br    = br;
    endtask

    task automatic fill_table();
        row_count = 0;
        // ----------------------------------------
        // Adder
        // ----------------------------------------
        add_row(int_alu_pkg::op_add, 64'h7FFFFFFF_FFFFFFFF, 64'h1, 64'h80000000_00000000, 1'b1);
        add_row(int_alu_pkg::op_add, 64'hFFFFFFFF_FFFFFFFF, 64'h2, 64'h1, 1'b1);
        add_row(int_alu_pkg::op_sub, 64'h5, 64'h7, 64'hFFFFFFFF_FFFFFFFE, 1'b1);
        add_row(int_alu_pkg::op_addw, 64'h7FFFFFFF, 64'h1, 64'hFFFFFFFF_80000000, 1'b1);
        add_row(int_alu_pkg::op_subw, 64'h0, 64'h1, 64'hFFFFFFFF_FFFFFFFF, 1'b1);
        add_row(int_alu_pkg::op_subw, 64'h80000000, 64'h1, 64'h7FFFFFFF, 1'b1);
        // Logic
        add_row(int_alu_pkg::op_and, 64'hF0F0F0F0_F0F0F0F0, 64'hFF00FF00_FF00FF00,
                64'hF000F000_F000F000, 1'b1);
        add_row(int_alu_pkg::op_or, 64'hF0F0F0F0_F0F0F0F0, 64'hFF00FF00_FF00FF00,
                64'hFFF0FFF0_FFF0FFF0, 1'b1);
        add_row(int_alu_pkg::op_xor, 64'hF0F0F0F0_F0F0F0F0, 64'hFF00FF00_FF00FF00,
                64'h0FF00FF0_0FF00FF0, 1'b1);
        // ----------------------------------------
        // Shifts
        // ----------------------------------------
        add_row(int_alu_pkg::op_sll, 64'h80000000_00000001, 64'd0, 64'h80000000_00000001, 1'b1);
        add_row(int_alu_pkg::op_sll, 64'h1, 64'd63, 64'h80000000_00000000, 1'b1);
        add_row(int_alu_pkg::op_srl, 64'h80000000_00000000, 64'd32, 64'h80000000, 1'b1);
        add_row(int_alu_pkg::op_sra, 64'h80000000_00000000, 64'd31, 64'hFFFFFFFF_00000000, 1'b1);
        add_row(int_alu_pkg::op_sra, 64'h80000000_00000000, 64'd63, 64'hFFFFFFFF_FFFFFFFF, 1'b1);
        add_row(int_alu_pkg::op_sllw, 64'h1, 64'd31, 64'hFFFFFFFF_80000000, 1'b1);
        add_row(int_alu_pkg::op_sllw, 64'hFFFFFFFF_00000001, 64'd32, 64'h1, 1'b1);
        add_row(int_alu_pkg::op_srlw, 64'h80000000, 64'd31, 64'h1, 1'b1);
        add_row(int_alu_pkg::op_sraw, 64'h80000000, 64'd31, 64'hFFFFFFFF_FFFFFFFF, 1'b1);
        add_row(int_alu_pkg::op_sraw, 64'hFFFFFFFF_40000000, 64'd63, 64'h0, 1'b1);
        // Set less than and branches
        add_row(int_alu_pkg::op_slts, 64'hFFFFFFFF_FFFFFFFF, 64'h1, 64'h1, 1'b1);
        add_row(int_alu_pkg::op_sltu, 64'hFFFFFFFF_FFFFFFFF, 64'h1, 64'h0, 1'b1);
        add_row(int_alu_pkg::op_eq, 64'h1234, 64'h1234, 64'h0, 1'b1);
        add_row(int_alu_pkg::op_ne, 64'h1234, 64'h1234, 64'h0, 1'b0);
        add_row(int_alu_pkg::op_lts, 64'hFFFFFFFF_FFFFFFFF, 64'h1, 64'h0, 1'b1);
        add_row(int_alu_pkg::op_ltu, 64'hFFFFFFFF_FFFFFFFF, 64'h1, 64'h0, 1'b0);
        add_row(int_alu_pkg::op_ges, 64'h5, 64'h5, 64'h0, 1'b1);
        add_row(int_alu_pkg::op_geu, 64'h1, 64'hFFFFFFFF_FFFFFFFF, 64'h0, 1'b0);
        add_row(int_alu_pkg::op_eq, 64'h5, 64'h6, 64'h0, 1'b0);
        add_row(int_alu_pkg::op_ne, 64'h5, 64'h6, 64'h0, 1'b1);
        add_row(int_alu_pkg::op_lts, 64'h1, 64'hFFFFFFFF_FFFFFFFF, 64'h0, 1'b0);
        add_row(int_alu_pkg::op_ltu, 64'h1, 64'hFFFFFFFF_FFFFFFFF, 64'h0, 1'b1);
        add_row(int_alu_pkg::op_ges, 64'hFFFFFFFF_FFFFFFFF, 64'h1, 64'h0, 1'b0);
        add_row(int_alu_pkg::op_geu, 64'hFFFFFFFF_FFFFFFFF, 64'h1, 64'h0, 1'b1);
        // ----------------------------------------
        // Polar lanes with clamp and -128 corners
        // ----------------------------------------
        add_row(int_alu_pkg::op_pl_r, 64'hDEADBEEF_80FF0085, 64'h01234567_0100017F,
                64'h00010001, 1'b1);
        add_row(int_alu_pkg::op_pl_f, 64'h800505FB_8005FB10, 64'h7FFDFEF0_7FFDFEF0,
                64'h81FD02F0, 1'b1);
        add_row(int_alu_pkg::op_pl_addsat, 64'h7F806410, 64'h01FF6414, 64'h7F817F24, 1'b1);
        add_row(int_alu_pkg::op_pl_subsat, 64'h209C0080, 64'h30328000, 64'hF0817F81, 1'b1);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("Verification failed");
        $finish;
    end

    initial begin
        seed        = 71;
        errors      = 0;
        checks      = 0;
        pend_valid  = 1'b0;
        arst_n_i    = 1'b1;
        op_i        = int_alu_pkg::op_add;
        operand_a_i = '0;
        operand_b_i = '0;
        fill_table();
        #1 arst_n_i = 1'b0;
        repeat (reset_cycles) @(posedge clk_i);
        arst_n_i <= 1'b1;

        // Outputs stay clear until the first edge out of reset
        @(negedge clk_i);
        check_value(result_o, '0, "result after reset");
        check_value(64'(branch_o), '0, "branch after reset");

        for (int i = 0; i < num_rows; i++) begin
            issue_op(tbl_op[i], tbl_a[i], tbl_b[i], tbl_res[i], tbl_br[i]);
        end

        // Random polar lanes
        for (int n = 0; n < num_random; n++) begin
            rand_op     = int_alu_pkg::alu_op_e'(int_alu_pkg::op_pl_r
                                                 + ($unsigned($random(seed)) % 4));
            rand_a.word = {$random(seed), $random(seed)};
            rand_b.word = {$random(seed), $random(seed)};
            rand_exp    = '0;
            for (int k = 0; k < `INT_ALU_LANES; k++) begin
                rand_exp[k*`INT_ALU_LANE_W +: `INT_ALU_LANE_W] =
                    polar_lane(rand_op, rand_a.simd.lanes[k], rand_b.simd.lanes[k]);
            end
            issue_op(rand_op, rand_a.word, rand_b.word, rand_exp, 1'b1);
        end

        @(posedge clk_i);
        @(negedge clk_i);
        check_pending();

        errors += dut.chk.assert_errors;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== test/int_alu_chk.sv ====
`timescale 1ns/1ps
`include "int_alu_config.svh"

module int_alu_chk (
    input logic                     clk_i,
    input logic                     arst_n_i,
    input int_alu_pkg::alu_op_e     op_i,
    input logic [`INT_ALU_XLEN-1:0] result_o,
    input logic                     branch_o
);

    logic is_polar;
    logic is_branch;
    logic is_slt;
    int   assert_errors = 0;

    assign is_polar  = op_i inside {int_alu_pkg::op_pl_r, int_alu_pkg::op_pl_f,
                                    int_alu_pkg::op_pl_addsat, int_alu_pkg::op_pl_subsat};
    assign is_branch = op_i inside {int_alu_pkg::op_eq, int_alu_pkg::op_ne,
                                    int_alu_pkg::op_lts, int_alu_pkg::op_ltu,
                                    int_alu_pkg::op_ges, int_alu_pkg::op_geu};
    assign is_slt    = op_i inside {int_alu_pkg::op_slts, int_alu_pkg::op_sltu};

    // ----------------------------------------
    // Output properties one cycle after issue
    // ----------------------------------------
    // The edge that releases reset still loads the reset state
    polar_upper_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        arst_n_i && is_polar |=> result_o[`INT_ALU_XLEN-1:`INT_ALU_WORD_W] == '0)
        else begin
            $error("Polar result has a nonzero upper half");
            assert_errors++;
        end

    non_branch_taken: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        arst_n_i && !is_branch |=> branch_o)
        else begin
            $error("Branch flag low after a non-branch operation");
            assert_errors++;
        end

    slt_single_bit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        arst_n_i && is_slt |=> result_o[`INT_ALU_XLEN-1:1] == '0)
        else begin
            $error("Set-less-than result has upper bits set");
            assert_errors++;
        end

    // Async reset keeps both outputs clear
    reset_clears: assert property (@(posedge clk_i)
        !arst_n_i |-> (result_o == '0) && !branch_o)
        else begin
            $error("Outputs not cleared while in reset");
            assert_errors++;
        end

endmodule

// ==== verilog/int_alu.sv ====
`timescale 1ns/1ps
`include "int_alu_config.svh"

module int_alu (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  int_alu_pkg::alu_op_e     op_i,
    input  logic [`INT_ALU_XLEN-1:0] operand_a_i,
    input  logic [`INT_ALU_XLEN-1:0] operand_b_i,
    output logic [`INT_ALU_XLEN-1:0] result_o,
    output logic                     branch_o
);

    logic [`INT_ALU_XLEN-1:0] add_result;
    logic                     add_zero;
    logic                     less;
    logic                     branch_taken;
    logic [`INT_ALU_XLEN-1:0] shift_result;
    logic [`INT_ALU_XLEN-1:0] polar_result;
    int_alu_pkg::operand_u    simd_a;
    int_alu_pkg::operand_u    simd_b;

    // Lane view of the operands for the polar unit
    assign simd_a = operand_a_i;
    assign simd_b = operand_b_i;

    // ----------------------------------------
    // Combinational units
    // ----------------------------------------
    alu_adder u_adder (
        .op_i         (op_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .add_result_o (add_result),
        .add_zero_o   (add_zero)
    );

    alu_shifter u_shifter (
        .op_i           (op_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .shift_result_o (shift_result)
    );

    alu_compare u_compare (
        .op_i           (op_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .add_zero_i     (add_zero),
        .less_o         (less),
        .branch_taken_o (branch_taken)
    );

    polar_simd u_polar (
        .op_i           (op_i),
        .operand_a_i    (simd_a),
        .operand_b_i    (simd_b),
        .polar_result_o (polar_result)
    );

    // Registered output stage
    alu_result_stage u_result (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .op_i           (op_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .add_result_i   (add_result),
        .less_i         (less),
        .branch_taken_i (branch_taken),
        .shift_result_i (shift_result),
        .polar_result_i (polar_result),
        .result_o       (result_o),
        .branch_o       (branch_o)
    );

endmodule

// ==== verilog/alu_result_stage.sv ====
`timescale 1ns/1ps
`include "int_alu_config.svh"

module alu_result_stage (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  int_alu_pkg::alu_op_e     op_i,
    input  logic [`INT_ALU_XLEN-1:0] operand_a_i,
    input  logic [`INT_ALU_XLEN-1:0] operand_b_i,
    input  logic [`INT_ALU_XLEN-1:0] add_result_i,
    input  logic                     less_i,
    input  logic                     branch_taken_i,
    input  logic [`INT_ALU_XLEN-1:0] shift_result_i,
    input  logic [`INT_ALU_XLEN-1:0] polar_result_i,
    output logic [`INT_ALU_XLEN-1:0] result_o,
    output logic                     branch_o
);

    logic [`INT_ALU_XLEN-1:0] add_word;
    logic [`INT_ALU_XLEN-1:0] result_d;

    // Word add keeps the low half and extends its sign
    assign add_word = {{(`INT_ALU_XLEN-`INT_ALU_WORD_W){add_result_i[`INT_ALU_WORD_W-1]}},
                       add_result_i[`INT_ALU_WORD_W-1:0]};

    // ----------------------------------------
    // Result select
    // ----------------------------------------
    always_comb begin
        unique case (op_i)
            int_alu_pkg::op_add,
            int_alu_pkg::op_sub:  result_d = add_result_i;
            int_alu_pkg::op_addw,
            int_alu_pkg::op_subw: result_d = add_word;
            int_alu_pkg::op_and:  result_d = operand_a_i & operand_b_i;
            int_alu_pkg::op_or:   result_d = operand_a_i | operand_b_i;
            int_alu_pkg::op_xor:  result_d = operand_a_i ^ operand_b_i;
            int_alu_pkg::op_sll,
            int_alu_pkg::op_srl,
            int_alu_pkg::op_sra,
            int_alu_pkg::op_sllw,
            int_alu_pkg::op_srlw,
            int_alu_pkg::op_sraw: result_d = shift_result_i;
            int_alu_pkg::op_slts,
            int_alu_pkg::op_sltu: result_d = {{(`INT_ALU_XLEN-1){1'b0}}, less_i};
            int_alu_pkg::op_pl_r,
            int_alu_pkg::op_pl_f,
            int_alu_pkg::op_pl_addsat,
            int_alu_pkg::op_pl_subsat: result_d = polar_result_i;
            // branch ops return zero
            default:              result_d = '0;
        endcase
    end

    // ----------------------------------------
    // Output register, one cycle latency
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_o <= '0;
            branch_o <= 1'b0;
        end else begin
            result_o <= result_d;
            branch_o <= branch_taken_i;
        end
    end

endmodule

// ==== verilog/polar_simd.sv ====
`timescale 1ns/1ps
`include "int_alu_config.svh"

module polar_simd (
    input  int_alu_pkg::alu_op_e     op_i,
    input  int_alu_pkg::operand_u    operand_a_i,
    input  int_alu_pkg::operand_u    operand_b_i,
    output logic [`INT_ALU_XLEN-1:0] polar_result_o
);

    localparam int VecW = `INT_ALU_LANES * `INT_ALU_LANE_W;
    localparam logic signed [`INT_ALU_LANE_W-1:0] SatHi = `INT_ALU_SAT_MAX;
    localparam logic signed [`INT_ALU_LANE_W-1:0] SatLo = `INT_ALU_SAT_MIN;

    logic [`INT_ALU_LANES-1:0][`INT_ALU_LANE_W-1:0] r_vec;
    logic [`INT_ALU_LANES-1:0][`INT_ALU_LANE_W-1:0] f_vec;
    logic [`INT_ALU_LANES-1:0][`INT_ALU_LANE_W-1:0] addsat_vec;
    logic [`INT_ALU_LANES-1:0][`INT_ALU_LANE_W-1:0] subsat_vec;

    // Clamp a 9-bit result into the symmetric lane range
    function automatic logic [`INT_ALU_LANE_W-1:0] saturate(
        input logic signed [`INT_ALU_LANE_W:0] value
    );
        if (value > SatHi) return SatHi;
        if (value < SatLo) return SatLo;
        return value[`INT_ALU_LANE_W-1:0];
    endfunction

    for (genvar i = 0; i < `INT_ALU_LANES; i++) begin : g_lane
        logic signed [`INT_ALU_LANE_W:0] a_ext;
        logic signed [`INT_ALU_LANE_W:0] b_ext;
        logic [`INT_ALU_LANE_W:0]        mag_a;
        logic [`INT_ALU_LANE_W:0]        mag_b;
        logic [`INT_ALU_LANE_W:0]        mag_min;

        assign a_ext = operand_a_i.simd.lanes[i];
        assign b_ext = operand_b_i.simd.lanes[i];

        // Magnitudes need the ninth bit for -128
        assign mag_a   = a_ext[`INT_ALU_LANE_W] ? -a_ext : a_ext;
        assign mag_b   = b_ext[`INT_ALU_LANE_W] ? -b_ext : b_ext;
        assign mag_min = (mag_a < mag_b) ? mag_a : mag_b;

        assign r_vec[i] = {{(`INT_ALU_LANE_W-1){1'b0}},
                           (b_ext != 1) && a_ext[`INT_ALU_LANE_W]};
        assign f_vec[i] = (a_ext[`INT_ALU_LANE_W] ^ b_ext[`INT_ALU_LANE_W])
                        ? ~mag_min[`INT_ALU_LANE_W-1:0] + 1'b1
                        : mag_min[`INT_ALU_LANE_W-1:0];

        assign addsat_vec[i] = saturate(a_ext + b_ext);
        assign subsat_vec[i] = saturate(a_ext - b_ext);
    end

    // Upper half of the word stays zero
    always_comb begin
        polar_result_o = '0;
        unique case (op_i)
            int_alu_pkg::op_pl_r:      polar_result_o[VecW-1:0] = r_vec;
            int_alu_pkg::op_pl_f:      polar_result_o[VecW-1:0] = f_vec;
            int_alu_pkg::op_pl_addsat: polar_result_o[VecW-1:0] = addsat_vec;
            int_alu_pkg::op_pl_subsat: polar_result_o[VecW-1:0] = subsat_vec;
            default: ;
        endcase
    end

endmodule

// ==== verilog/alu_compare.sv ====
`timescale 1ns/1ps
`include "int_alu_config.svh"

module alu_compare (
    input  int_alu_pkg::alu_op_e     op_i,
    input  logic [`INT_ALU_XLEN-1:0] operand_a_i,
    input  logic [`INT_ALU_XLEN-1:0] operand_b_i,
    input  logic                     add_zero_i,
    output logic                     less_o,
    output logic                     branch_taken_o
);

    logic                   signed_cmp;
    logic [`INT_ALU_XLEN:0] cmp_a;
    logic [`INT_ALU_XLEN:0] cmp_b;

    assign signed_cmp = op_i inside {int_alu_pkg::op_slts, int_alu_pkg::op_lts,
                                     int_alu_pkg::op_ges};

    // One extra bit makes a single signed compare serve both forms
    assign cmp_a  = {signed_cmp & operand_a_i[`INT_ALU_XLEN-1], operand_a_i};
    assign cmp_b  = {signed_cmp & operand_b_i[`INT_ALU_XLEN-1], operand_b_i};
    assign less_o = $signed(cmp_a) < $signed(cmp_b);

    // Non-branch operators report taken
    always_comb begin
        unique case (op_i)
            int_alu_pkg::op_eq:  branch_taken_o = add_zero_i;
            int_alu_pkg::op_ne:  branch_taken_o = ~add_zero_i;
            int_alu_pkg::op_lts,
            int_alu_pkg::op_ltu: branch_taken_o = less_o;
            int_alu_pkg::op_ges,
            int_alu_pkg::op_geu: branch_taken_o = ~less_o;
            default:             branch_taken_o = 1'b1;
        endcase
    end

endmodule

// ==== verilog/alu_shifter.sv ====
`timescale 1ns/1ps
`include "int_alu_config.svh"

module alu_shifter (
    input  int_alu_pkg::alu_op_e     op_i,
    input  logic [`INT_ALU_XLEN-1:0] operand_a_i,
    input  logic [`INT_ALU_XLEN-1:0] operand_b_i,
    output logic [`INT_ALU_XLEN-1:0] shift_result_o
);

    localparam int ShamtW   = $clog2(`INT_ALU_XLEN);
    localparam int ShamtW32 = $clog2(`INT_ALU_WORD_W);

    logic                       shift_left;
    logic                       shift_arith;
    logic                       shift_word;
    logic [`INT_ALU_XLEN-1:0]   a_rev;
    logic [`INT_ALU_WORD_W-1:0] a_rev32;
    logic [`INT_ALU_XLEN:0]     shift_in;
    logic [`INT_ALU_WORD_W:0]   shift_in32;
    logic [`INT_ALU_XLEN:0]     right_res;
    logic [`INT_ALU_WORD_W:0]   right_res32;
    logic [`INT_ALU_XLEN-1:0]   left_res;
    logic [`INT_ALU_WORD_W-1:0] left_res32;
    logic [`INT_ALU_WORD_W-1:0] word_res;

    assign shift_left  = op_i inside {int_alu_pkg::op_sll, int_alu_pkg::op_sllw};
    assign shift_arith = op_i inside {int_alu_pkg::op_sra, int_alu_pkg::op_sraw};
    assign shift_word  = op_i inside {int_alu_pkg::op_sllw, int_alu_pkg::op_srlw,
                                      int_alu_pkg::op_sraw};

    // Left shift as reverse, shift right, reverse back
    for (genvar k = 0; k < `INT_ALU_XLEN; k++) begin : g_rev64
        assign a_rev[k]    = operand_a_i[`INT_ALU_XLEN-1-k];
        assign left_res[k] = right_res[`INT_ALU_XLEN-1-k];
    end

    for (genvar k = 0; k < `INT_ALU_WORD_W; k++) begin : g_rev32
        assign a_rev32[k]    = operand_a_i[`INT_ALU_WORD_W-1-k];
        assign left_res32[k] = right_res32[`INT_ALU_WORD_W-1-k];
    end

    // Extra top bit is the fill bit, zero unless arithmetic
    assign shift_in   = {shift_arith & operand_a_i[`INT_ALU_XLEN-1],
                         shift_left ? a_rev : operand_a_i};
    assign shift_in32 = {shift_arith & operand_a_i[`INT_ALU_WORD_W-1],
                         shift_left ? a_rev32 : operand_a_i[`INT_ALU_WORD_W-1:0]};

    assign right_res   = $unsigned($signed(shift_in) >>> operand_b_i[ShamtW-1:0]);
    assign right_res32 = $unsigned($signed(shift_in32) >>> operand_b_i[ShamtW32-1:0]);

    assign word_res = shift_left ? left_res32 : right_res32[`INT_ALU_WORD_W-1:0];

    always_comb begin
        if (shift_word) begin
            shift_result_o = {{(`INT_ALU_XLEN-`INT_ALU_WORD_W){word_res[`INT_ALU_WORD_W-1]}},
                              word_res};
        end else begin
            shift_result_o = shift_left ? left_res : right_res[`INT_ALU_XLEN-1:0];
        end
    end

endmodule

// ==== verilog/alu_adder.sv ====
`timescale 1ns/1ps
`include "int_alu_config.svh"

module alu_adder (
    input  int_alu_pkg::alu_op_e     op_i,
    input  logic [`INT_ALU_XLEN-1:0] operand_a_i,
    input  logic [`INT_ALU_XLEN-1:0] operand_b_i,
    output logic [`INT_ALU_XLEN-1:0] add_result_o,
    output logic                     add_zero_o
);

    logic                   negate_b;
    logic [`INT_ALU_XLEN:0] adder_in_a;
    logic [`INT_ALU_XLEN:0] adder_in_b;
    logic [`INT_ALU_XLEN:0] adder_sum;

    // Subtraction for sub forms and equality tests
    always_comb begin
        negate_b = 1'b0;
        unique case (op_i)
            int_alu_pkg::op_sub,
            int_alu_pkg::op_subw,
            int_alu_pkg::op_eq,
            int_alu_pkg::op_ne: negate_b = 1'b1;
            default: ;
        endcase
    end

    // Extra low bit carries the +1 of the two's complement
    assign adder_in_a = {operand_a_i, 1'b1};
    assign adder_in_b = {operand_b_i ^ {`INT_ALU_XLEN{negate_b}}, negate_b};
    assign adder_sum  = adder_in_a + adder_in_b;

    assign add_result_o = adder_sum[`INT_ALU_XLEN:1];
    assign add_zero_o   = ~|add_result_o;

endmodule

// ==== verilog/int_alu_pkg.sv ====
`include "int_alu_config.svh"

package int_alu_pkg;

    // Operator encoding shared by every unit
    typedef enum logic [4:0] {
        op_add, op_sub, op_addw, op_subw,
        // Bitwise
        op_and, op_or, op_xor,
        // Shifts, 64-bit then word forms
        op_sll, op_srl, op_sra,
        op_sllw, op_srlw, op_sraw,
        // Set less than
        op_slts, op_sltu,
        // Branch resolution
        op_eq, op_ne,
        op_lts, op_ltu,
        op_ges, op_geu,
        // Polar decoding lanes
        op_pl_r, op_pl_f,
        op_pl_addsat, op_pl_subsat
    } alu_op_e;

    // One signed polar lane
    typedef logic signed [`INT_ALU_LANE_W-1:0] lane_t;

    // Lane view of an operand, lane 0 in the low byte
    typedef struct packed {
        logic [`INT_ALU_XLEN-`INT_ALU_LANES*`INT_ALU_LANE_W-1:0] unused;
        lane_t [`INT_ALU_LANES-1:0]                                 lanes;
    } simd_t;

    // Same 64-bit operand seen as a scalar or as packed lanes
    typedef union packed {
        logic [`INT_ALU_XLEN-1:0] word;
        simd_t                    simd;
    } operand_u;

endpackage

// ==== verilog/int_alu_config.svh ====
`ifndef INT_ALU_CONFIG_SVH
`define INT_ALU_CONFIG_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------
`define INT_ALU_XLEN 64
`define INT_ALU_WORD_W 32

// ----------------------------------------
// Polar SIMD lanes
// ----------------------------------------
`define INT_ALU_LANES 4
`define INT_ALU_LANE_W 8

// Symmetric clamp, -128 is never produced by the saturating ops
`define INT_ALU_SAT_MAX 127
`define INT_ALU_SAT_MIN (-127)

`endif
